// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_emu_ram
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM       ?= $(BUILD_DIR)/V$(TOP)
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== compile.f ====
+incdir+.
emu_pkg.sv
tick_channel.sv
emu_mem_backend.sv
tick_scheduler.sv
emu_ctrl_regs.sv
emu_ram_top.sv
tb_emu_ram.sv

// ==== emu_consts.svh ====
`ifndef EMU_CONSTS_SVH
`define EMU_CONSTS_SVH

// target memory geometry.
`define EMU_ADDR_W      6
`define EMU_DATA_W      32
`define EMU_MEM_DEPTH   64

// host cycles from command fire to read response.
`define EMU_RD_LAT      3

// tick counter and budget width.
`define EMU_CNT_W       16

// host register map.
`define EMU_REG_CTRL    2'd0
`define EMU_REG_LIMIT   2'd1
`define EMU_REG_COUNT   2'd2
`define EMU_REG_STATUS  2'd3

`endif

// ==== emu_ctrl_regs.sv ====
`timescale 1ns/1ps
`include "emu_consts.svh"

module emu_ctrl_regs (
    input  logic                   host_clk,
    input  logic                   tk_rst_fire,
    input  logic                   reg_wr,
    input  logic                   reg_rd,
    input  emu_pkg::emu_reg_addr_t reg_addr,
    input  logic [`EMU_DATA_W-1:0] reg_wdata,
    input  logic [`EMU_CNT_W-1:0]  tick_count,
    input  logic                   halted,
    input  logic                   idle,
    output logic                   run,
    output logic [`EMU_CNT_W-1:0]  tick_limit,
    output logic [`EMU_DATA_W-1:0] reg_rdata
);

    logic [`EMU_DATA_W-1:0] rd_mux;

    always_comb begin
        rd_mux = '0;
        case (reg_addr)
            `EMU_REG_CTRL:   rd_mux[0] = run;
            `EMU_REG_LIMIT:  rd_mux[`EMU_CNT_W-1:0] = tick_limit;
            `EMU_REG_COUNT:  rd_mux[`EMU_CNT_W-1:0] = tick_count;
            `EMU_REG_STATUS: rd_mux[1:0] = {halted, idle};
            default:         rd_mux = '0;
        endcase
    end

    // COUNT and STATUS ignore writes.
    always_ff @(posedge host_clk) begin
        if (tk_rst_fire) begin
            run        <= 1'b0;
            tick_limit <= '0;
        end else if (reg_wr) begin
            case (reg_addr)
                `EMU_REG_CTRL:  run <= reg_wdata[0];
                `EMU_REG_LIMIT: tick_limit <= reg_wdata[`EMU_CNT_W-1:0];
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge host_clk) begin
        if (tk_rst_fire) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            reg_rdata <= rd_mux;   // held until the next read.
        end
    end

endmodule

// ==== emu_mem_backend.sv ====
`timescale 1ns/1ps
`include "emu_consts.svh"

module emu_mem_backend (
    input  logic              host_clk,
    input  logic              tk_rst_fire,
    input  logic              cmd_valid,
    input  emu_pkg::emu_cmd_t cmd,
    output logic              cmd_ready,
    output logic              rsp_valid,
    output emu_pkg::emu_rsp_t rsp,
    input  logic              rsp_ready,
    output logic              idle
);
    import emu_pkg::*;

    localparam int LAT_W = $clog2(`EMU_RD_LAT + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_RESP
    } state_e;

    state_e                 state;
    logic [LAT_W-1:0]       lat_cnt;
    logic [LAT_W-1:0]       cmd_lat;
    emu_op_e                op_q;
    logic [`EMU_ADDR_W-1:0] addr_q;
    emu_rsp_t               rsp_q;
    logic [`EMU_DATA_W-1:0] mem [`EMU_MEM_DEPTH];
    logic                   cmd_fire;
    logic                   rsp_fire;
    logic                   wait_last;

    assign cmd_ready = (state == ST_IDLE);   // one command in flight at most.
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign rsp_valid = (state == ST_RESP);
    assign rsp_fire  = rsp_valid && rsp_ready;
    assign rsp       = rsp_q;
    assign idle      = (state == ST_IDLE);
    assign wait_last = (state == ST_WAIT) && (lat_cnt == LAT_W'(1));

    assign cmd_lat = (cmd.op == EMU_OP_READ) ? LAT_W'(`EMU_RD_LAT) : LAT_W'(1);

    // storage starts out as all zeros and survives reset.
    initial begin
        for (int i = 0; i < `EMU_MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge host_clk) begin
        if (tk_rst_fire) begin
            state   <= ST_IDLE;
            lat_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (cmd_fire) begin
                        lat_cnt <= cmd_lat - 1'b1;
                        state   <= (cmd_lat == LAT_W'(1)) ? ST_RESP : ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    lat_cnt <= lat_cnt - 1'b1;
                    if (wait_last) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (rsp_fire) begin
                        state <= ST_IDLE;   // hand back to the next step.
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge host_clk) begin
        if (cmd_fire) begin
            op_q   <= cmd.op;
            addr_q <= cmd.addr;
            if (cmd.op == EMU_OP_WRITE) begin
                mem[cmd.addr] <= cmd.wdata;
            end
        end
    end

    // response word is built on the way into ST_RESP.
    always_ff @(posedge host_clk) begin
        if (cmd_fire && cmd_lat == LAT_W'(1)) begin
            rsp_q.valid <= (cmd.op == EMU_OP_READ);
            rsp_q.rdata <= (cmd.op == EMU_OP_READ) ? mem[cmd.addr] : '0;
        end else if (wait_last) begin
            rsp_q.valid <= (op_q == EMU_OP_READ);
            rsp_q.rdata <= (op_q == EMU_OP_READ) ? mem[addr_q] : '0;
        end
    end

endmodule

// ==== emu_pkg.sv ====
`include "emu_consts.svh"

package emu_pkg;

    // command kind presented by the target each step.
    typedef enum logic [1:0] {
        EMU_OP_NOP   = 2'd0,
        EMU_OP_READ  = 2'd1,
        EMU_OP_WRITE = 2'd2
    } emu_op_e;

    // one command token, 40 bits.
    typedef struct packed {
        emu_op_e                op;
        logic [`EMU_ADDR_W-1:0] addr;
        logic [`EMU_DATA_W-1:0] wdata;
    } emu_cmd_t;

    // one response token, valid only for reads.
    typedef struct packed {
        logic                   valid;
        logic [`EMU_DATA_W-1:0] rdata;
    } emu_rsp_t;

    typedef logic [1:0] emu_reg_addr_t;

endpackage

// ==== emu_ram_golden.txt ====
# op  field_a  field_b (hex). REGWR addr data, REGRD addr expected, TGTWR addr wdata,
# TGTRD addr expected_rdata, TGTNOP unused unused, WAITHALT watch_cycles unused.
REGRD    3  00000001
REGRD    2  00000000
REGRD    0  00000000
REGWR    1  00000005
REGRD    1  00000005
REGWR    0  00000001
TGTWR    05 deadbeef
TGTRD    05 deadbeef
TGTRD    2a 00000000
TGTNOP   00 00000000
TGTWR    10 12345678
WAITHALT 14 00000000
REGRD    3  00000003
REGRD    2  00000005
REGRD    0  00000001
REGWR    2  0000ffff
REGRD    2  00000005
REGWR    3  00000000
REGRD    3  00000003
REGWR    1  0000000a
TGTWR    3f a5a5a5a5
TGTRD    10 12345678
REGWR    0  00000000
REGWR    0  00000001
TGTRD    3f a5a5a5a5
TGTNOP   00 00000000
TGTRD    00 00000000
WAITHALT 14 00000000
REGRD    2  0000000a
REGRD    3  00000003
REGRD    1  0000000a
REGRD    0  00000001

// ==== emu_ram_top.sv ====
`timescale 1ns/1ps
`include "emu_consts.svh"

module emu_ram_top (
    input  logic                   host_clk,
    input  logic                   tk_rst_fire,
    input  logic                   reg_wr,
    input  logic                   reg_rd,
    input  emu_pkg::emu_reg_addr_t reg_addr,
    input  logic [`EMU_DATA_W-1:0] reg_wdata,
    output logic [`EMU_DATA_W-1:0] reg_rdata,
    input  emu_pkg::emu_op_e       tgt_cmd_op,
    input  logic [`EMU_ADDR_W-1:0] tgt_cmd_addr,
    input  logic [`EMU_DATA_W-1:0] tgt_cmd_wdata,
    output logic                   tgt_en,
    output logic                   tgt_rsp_valid,
    output logic [`EMU_DATA_W-1:0] tgt_rsp_rdata,
    output logic                   finishing,
    output logic                   idle
);
    import emu_pkg::*;

    logic                  run;
    logic [`EMU_CNT_W-1:0] tick_limit;
    logic [`EMU_CNT_W-1:0] tick_count;
    logic                  halted;
    logic                  run_active;
    logic                  tick;
    logic                  cmd_complete;
    logic                  rsp_complete;
    logic                  cmd_valid;
    logic                  cmd_ready;
    logic                  rsp_valid;
    logic                  rsp_ready;
    emu_cmd_t              tgt_cmd;
    emu_cmd_t              cmd_held;
    emu_rsp_t              rsp;
    emu_rsp_t              rsp_held;

    assign tgt_cmd       = '{op: tgt_cmd_op, addr: tgt_cmd_addr, wdata: tgt_cmd_wdata};
    assign tgt_en        = tick;
    assign tgt_rsp_valid = rsp_held.valid;
    assign tgt_rsp_rdata = rsp_held.rdata;

    emu_ctrl_regs regs_i (
        .host_clk    (host_clk),
        .tk_rst_fire (tk_rst_fire),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .tick_count  (tick_count),
        .halted      (halted),
        .idle        (idle),
        .run         (run),
        .tick_limit  (tick_limit),
        .reg_rdata   (reg_rdata)
    );

    tick_scheduler sched_i (
        .host_clk     (host_clk),
        .tk_rst_fire  (tk_rst_fire),
        .run          (run),
        .tick_limit   (tick_limit),
        .cmd_complete (cmd_complete),
        .rsp_complete (rsp_complete),
        .run_active   (run_active),
        .tick         (tick),
        .finishing    (finishing),
        .tick_count   (tick_count),
        .halted       (halted)
    );

    // host side offers the command, backend accepts it.
    tick_channel #(.payload_t(emu_cmd_t)) cmd_chan (
        .host_clk     (host_clk),
        .tk_rst_fire  (tk_rst_fire),
        .run_active   (run_active),
        .tick         (tick),
        .peer         (cmd_ready),
        .in_payload   (tgt_cmd),
        .open         (cmd_valid),
        .fire         (),
        .done         (),
        .complete     (cmd_complete),
        .held_payload (cmd_held)
    );

    // backend offers the response, host side accepts it.
    tick_channel #(.payload_t(emu_rsp_t)) rsp_chan (
        .host_clk     (host_clk),
        .tk_rst_fire  (tk_rst_fire),
        .run_active   (run_active),
        .tick         (tick),
        .peer         (rsp_valid),
        .in_payload   (rsp),
        .open         (rsp_ready),
        .fire         (),
        .done         (),
        .complete     (rsp_complete),
        .held_payload (rsp_held)
    );

    emu_mem_backend backend_i (
        .host_clk    (host_clk),
        .tk_rst_fire (tk_rst_fire),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd_held),
        .cmd_ready   (cmd_ready),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp),
        .rsp_ready   (rsp_ready),
        .idle        (idle)
    );

endmodule

// ==== tb_emu_ram.sv ====
`timescale 1ns/1ps
`include "emu_consts.svh"

module tb_emu_ram;
    import emu_pkg::*;

    localparam int    CLK_PERIOD  = 8;
    localparam string GOLDEN_FILE = "emu_ram_golden.txt";

    logic                   host_clk;
    logic                   tk_rst_fire;
    logic                   reg_wr;
    logic                   reg_rd;
    emu_reg_addr_t          reg_addr;
    logic [`EMU_DATA_W-1:0] reg_wdata;
    logic [`EMU_DATA_W-1:0] reg_rdata;
    emu_op_e                tgt_cmd_op;
    logic [`EMU_ADDR_W-1:0] tgt_cmd_addr;
    logic [`EMU_DATA_W-1:0] tgt_cmd_wdata;
    logic                   tgt_en;
    logic                   tgt_rsp_valid;
    logic [`EMU_DATA_W-1:0] tgt_rsp_rdata;
    logic                   finishing;
    logic                   idle;

    string                  kinds[$];
    logic [31:0]            field_a[$];
    logic [31:0]            field_b[$];
    int                     tick_seen = 0;
    int                     ops_done = 0;
    int                     cycle_count = 0;
    int                     cycle_limit = 200;
    logic                   cap_valid;
    logic [`EMU_DATA_W-1:0] cap_rdata;

    emu_ram_top emu_ram_top_i (
        .host_clk      (host_clk),
        .tk_rst_fire   (tk_rst_fire),
        .reg_wr        (reg_wr),
        .reg_rd        (reg_rd),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .reg_rdata     (reg_rdata),
        .tgt_cmd_op    (tgt_cmd_op),
        .tgt_cmd_addr  (tgt_cmd_addr),
        .tgt_cmd_wdata (tgt_cmd_wdata),
        .tgt_en        (tgt_en),
        .tgt_rsp_valid (tgt_rsp_valid),
        .tgt_rsp_rdata (tgt_rsp_rdata),
        .finishing     (finishing),
        .idle          (idle)
    );

    initial begin
        host_clk = 1'b0;
        forever #(CLK_PERIOD / 2) host_clk = ~host_clk;
    end

    // response is captured mid-cycle, while it is stable.
    always @(negedge host_clk) begin
        if (tgt_en) begin
            tick_seen <= tick_seen + 1;
            cap_valid <= tgt_rsp_valid;
            cap_rdata <= tgt_rsp_rdata;
        end
    end

    always @(posedge host_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            fail_run($sformatf("Timeout: run exceeded %0d host cycles", cycle_limit));
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_word(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) else begin
            fail_run($sformatf("Mismatch %s: expected 0x%08h, actual 0x%08h",
                               name, expected, actual));
        end
    endtask

    function automatic bit is_target(input string kind);
        return (kind == "TGTWR") || (kind == "TGTRD") || (kind == "TGTNOP");
    endfunction

    function automatic bit is_register(input string kind);
        return (kind == "REGWR") || (kind == "REGRD");
    endfunction

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        string       kind;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            fail_run("Could not open the golden file");
        end
        while ($fgets(line, fd) > 0) begin
            n = $sscanf(line, "%s %h %h", kind, a, b);
            if (n == 3 && kind.getc(0) != "#") begin
                kinds.push_back(kind);
                field_a.push_back(a);
                field_b.push_back(b);
            end
        end
        $fclose(fd);
    endtask

    task automatic idle_cycles(input int unsigned n);
        repeat (n) begin
            @(posedge host_clk);
            #1;
        end
    endtask

    // the target shows the command of the next step as soon as the last one ends.
    task automatic present_next_cmd(input int from);
        int k;
        k = from;
        while (k < kinds.size() && !is_target(kinds[k])) begin
            k++;
        end
        tgt_cmd_op    = EMU_OP_NOP;
        tgt_cmd_addr  = '0;
        tgt_cmd_wdata = '0;
        if (k < kinds.size()) begin
            tgt_cmd_addr = field_a[k][`EMU_ADDR_W-1:0];
            if (kinds[k] == "TGTWR") begin
                tgt_cmd_op    = EMU_OP_WRITE;
                tgt_cmd_wdata = field_b[k];
            end else if (kinds[k] == "TGTRD") begin
                tgt_cmd_op = EMU_OP_READ;
            end
        end
    endtask

    task automatic write_register(input logic [1:0] addr, input logic [31:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(posedge host_clk);
        #1;
        reg_wr = 1'b0;
    endtask

    task automatic read_register(input logic [1:0] addr, output logic [31:0] value);
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(posedge host_clk);
        #1;
        reg_rd = 1'b0;
        value  = reg_rdata;
    endtask

    task automatic run_target_op(input string kind, input logic [31:0] b, input int idx);
        logic                   exp_valid;
        logic [`EMU_DATA_W-1:0] exp_rdata;
        exp_valid = (kind == "TGTRD");
        exp_rdata = exp_valid ? b : '0;   // nop and write return nothing.
        while (tick_seen == ops_done) begin
            @(posedge host_clk);
            #1;
        end
        ops_done++;
        assert (!tgt_en) else begin
            fail_run("tgt_en stayed high for more than one host cycle");
        end
        compare_word("tgt_rsp_valid", {31'b0, exp_valid}, {31'b0, cap_valid});
        compare_word("tgt_rsp_rdata", exp_rdata, cap_rdata);
        present_next_cmd(idx + 1);
    endtask

    task automatic wait_halted(input int unsigned watch);
        logic [31:0] status;
        status = '0;
        while (!status[1]) begin
            read_register(`EMU_REG_STATUS, status);
        end
        idle_cycles(watch);
    endtask

    initial begin
        int unsigned gap;
        logic [31:0] value;
        tk_rst_fire   = 1'b1;
        reg_wr        = 1'b0;
        reg_rd        = 1'b0;
        reg_addr      = '0;
        reg_wdata     = '0;
        tgt_cmd_op    = EMU_OP_NOP;
        tgt_cmd_addr  = '0;
        tgt_cmd_wdata = '0;
        void'($urandom(60));
        load_golden();
        cycle_limit = 64 * kinds.size() + 200;
        present_next_cmd(0);
        repeat (4) @(posedge host_clk);
        #1;
        tk_rst_fire = 1'b0;

        for (int c = 0; c < 20; c++) begin
            assert (!tgt_en && !finishing && idle) else begin
                fail_run("tgt_en or finishing active, or backend busy, before run was set");
            end
            idle_cycles(1);
        end

        for (int i = 0; i < kinds.size(); i++) begin
            if (i > 0 && is_register(kinds[i - 1]) && is_register(kinds[i])) begin
                gap = 10 + ($urandom % 21);
                idle_cycles(gap);
            end
            if (!is_target(kinds[i])) begin
                assert (tick_seen == ops_done) else begin
                    fail_run($sformatf("Unexpected tgt_en pulse before golden line %0d", i));
                end
            end
            if (kinds[i] == "REGWR") begin
                write_register(field_a[i][1:0], field_b[i]);
            end else if (kinds[i] == "REGRD") begin
                read_register(field_a[i][1:0], value);
                compare_word($sformatf("reg_rdata (addr %0d)", field_a[i][1:0]),
                             field_b[i], value);
            end else if (is_target(kinds[i])) begin
                run_target_op(kinds[i], field_b[i], i);
            end else if (kinds[i] == "WAITHALT") begin
                wait_halted(field_a[i]);
            end else begin
                fail_run($sformatf("Unknown opcode %s in golden line %0d", kinds[i], i));
            end
        end

        assert (tick_seen == ops_done) else begin
            fail_run("Unexpected tgt_en pulse after the last golden line");
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== tick_channel.sv ====
`timescale 1ns/1ps

module tick_channel #(
    parameter type payload_t = logic
) (
    input  logic     host_clk,
    input  logic     tk_rst_fire,
    input  logic     run_active,
    input  logic     tick,
    input  logic     peer,
    input  payload_t in_payload,
    output logic     open,
    output logic     fire,
    output logic     done,
    output logic     complete,
    output payload_t held_payload
);

    payload_t held_q;

    assign open     = run_active && !done;  // closed once this step's token crossed.
    assign fire     = open && peer;
    assign complete = fire || done;

    // the token of this step is visible in the cycle it crosses.
    assign held_payload = fire ? in_payload : held_q;

    always_ff @(posedge host_clk) begin
        if (tk_rst_fire || tick) begin
            done <= 1'b0;
        end else if (fire) begin
            done <= 1'b1;
        end
    end

    always_ff @(posedge host_clk) begin
        if (fire) begin
            held_q <= in_payload;
        end
    end

endmodule

// ==== tick_scheduler.sv ====
`timescale 1ns/1ps
`include "emu_consts.svh"

module tick_scheduler (
    input  logic                  host_clk,
    input  logic                  tk_rst_fire,
    input  logic                  run,
    input  logic [`EMU_CNT_W-1:0] tick_limit,
    input  logic                  cmd_complete,
    input  logic                  rsp_complete,
    output logic                  run_active,
    output logic                  tick,
    output logic                  finishing,
    output logic [`EMU_CNT_W-1:0] tick_count,
    output logic                  halted
);

    logic limit_set;

    assign finishing = cmd_complete && rsp_complete;   // every channel crossed or done.

    // a zero budget means run without limit.
    assign limit_set = (tick_limit != '0);
    assign halted    = limit_set && (tick_limit == tick_count);

    assign run_active = run && !halted;
    assign tick       = run_active && finishing;     // single-cycle target enable.

    always_ff @(posedge host_clk) begin
        if (tk_rst_fire) begin
            tick_count <= '0;
        end else if (tick) begin
            tick_count <= tick_count + 1'b1;
        end
    end

endmodule
